// ==== project.f ====
+incdir+testbench
rtl/mcr3_input_pkg.sv
rtl/dl_config.sv
rtl/player_select.sv
rtl/steering_emu.sv
rtl/spinner_emu.sv
rtl/input_port_mux.sv
rtl/mcr3_input_top.sv
testbench/tb_mcr3_input.sv

// ==== rtl/dl_config.sv ====
//======================================================================
// Download configuration decoder
// Captures the game byte and the DIP switch bank from download writes
//======================================================================
`default_nettype none
`timescale 1ns/1ps

module dl_config (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  wire         dl_wr,
	input  wire  [7:0]  dl_index,
	input  wire  [24:0] dl_addr,
	input  wire  [7:0]  dl_data,
	output mcr3_input_pkg::game_e game,
	output logic [7:0]  dip0,
	output logic        service
);

	logic [7:0] game_byte;
	logic [7:0] dip_bank [mcr3_input_pkg::DIP_COUNT];
	logic       dip_hit;

	// Only the first eight addresses of the DIP index are stored
	assign dip_hit = dl_wr && (dl_index == mcr3_input_pkg::DL_INDEX_DIP) &&
		(dl_addr[24:3] == '0);

	// Game byte and its decoded form
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			game_byte <= 8'hFF;
			game      <= mcr3_input_pkg::game_none;
		end else begin
			if (dl_wr && (dl_index == mcr3_input_pkg::DL_INDEX_GAME))
				game_byte <= dl_data;
			case (game_byte)
				8'd0:    game <= mcr3_input_pkg::game_spy_hunter;
				8'd1:    game <= mcr3_input_pkg::game_turbo;
				8'd2:    game <= mcr3_input_pkg::game_crater;
				default: game <= mcr3_input_pkg::game_none;
			endcase
		end
	end

	// DIP bank holds whatever was last downloaded
	always_ff @(posedge clk_sys) begin
		if (dip_hit)
			dip_bank[dl_addr[2:0]] <= dl_data;
		dip0    <= dip_bank[0];
		service <= dip_bank[1][0];
	end

endmodule

`default_nettype wire

// ==== rtl/input_port_mux.sv ====
//======================================================================
// CPU input port formatter
// Builds the five game input ports and the landscape flag per game
//======================================================================
`default_nettype none
`timescale 1ns/1ps

module input_port_mux (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  wire  mcr3_input_pkg::game_e game,
	input  wire  [7:0]  dip0,
	input  wire         service,
	input  wire  [31:0] btn,
	input  wire  [15:0] joy_a,
	input  wire  [7:0]  pd,
	input  wire  [7:0]  steering,
	input  wire  [7:0]  gas,
	input  wire  [7:0]  angle,
	input  wire         opt_analog_gas,
	input  wire  mcr3_input_pkg::steer_mode_e steer_mode,
	input  wire         port_sel,
	output logic [7:0]  input_0,
	output logic [7:0]  input_1,
	output logic [7:0]  input_2,
	output logic [7:0]  input_3,
	output logic [7:0]  input_4,
	output logic        landscape
);

	logic [7:0] steer_x;
	logic [7:0] steer_p;
	logic [7:0] steer_sel;
	logic [7:0] gas_raw;
	logic [7:0] gas_ana;
	logic [7:0] drive_val;
	logic       turbo_shift;
	logic [7:0] in0_next;
	logic [7:0] in1_next;
	logic [7:0] in2_next;
	logic       landscape_next;

	//==================================================================
	// Steering and gas for the driving games
	//==================================================================
	always_comb begin
		// Horizontal axis halved around center, paddle offset by its top bit
		steer_x = mcr3_input_pkg::STEER_CENTER + {joy_a[7], joy_a[7:1]};
		steer_p = mcr3_input_pkg::STEER_CENTER + {~pd[7], ~pd[7], pd[6:1]};
		case (steer_mode)
			mcr3_input_pkg::steer_analog_x: steer_sel = steer_x;
			mcr3_input_pkg::steer_paddle:   steer_sel = steer_p;
			default:                        steer_sel = steering;
		endcase

		// Stick pushed up is negative, Turbo also accepts the pull-back half
		if (joy_a[15])
			gas_raw = 8'h00 - joy_a[15:8];
		else if (game == mcr3_input_pkg::game_turbo)
			gas_raw = joy_a[15:8];
		else
			gas_raw = '0;
		gas_ana = {gas_raw[6:0], 1'b1};

		// Output port bit 7 of the game CPU picks steering or gas
		if (port_sel)
			drive_val = steer_sel;
		else if (opt_analog_gas)
			drive_val = gas_ana;
		else
			drive_val = gas;

		turbo_shift = opt_analog_gas ? ~joy_a[15] : btn[mcr3_input_pkg::JOY_SHIFT];
	end

	//==================================================================
	// Per-game port layout, active low except where noted
	//==================================================================
	always_comb begin
		in0_next       = mcr3_input_pkg::PORT_IDLE;
		in1_next       = mcr3_input_pkg::PORT_IDLE;
		in2_next       = mcr3_input_pkg::PORT_IDLE;
		landscape_next = 1'b0;
		case (game)
			mcr3_input_pkg::game_spy_hunter: begin
				in0_next = ~{service, 2'b00, btn[mcr3_input_pkg::JOY_SHIFT], 3'b000,
					btn[mcr3_input_pkg::JOY_COIN]};
				in1_next = ~{3'b000, btn[mcr3_input_pkg::JOY_FIRE_A],
					btn[mcr3_input_pkg::JOY_FIRE_C], btn[mcr3_input_pkg::JOY_FIRE_E],
					btn[mcr3_input_pkg::JOY_FIRE_B], btn[mcr3_input_pkg::JOY_FIRE_D]};
				in2_next = drive_val;
			end
			mcr3_input_pkg::game_turbo: begin
				in0_next = ~{service, 2'b00, turbo_shift, 3'b000,
					btn[mcr3_input_pkg::JOY_COIN]};
				in1_next = ~{3'b000, btn[mcr3_input_pkg::JOY_FIRE_E],
					btn[mcr3_input_pkg::JOY_FIRE_D], btn[mcr3_input_pkg::JOY_FIRE_C],
					btn[mcr3_input_pkg::JOY_FIRE_B], btn[mcr3_input_pkg::JOY_FIRE_A]};
				in2_next = drive_val;
			end
			mcr3_input_pkg::game_crater: begin
				landscape_next = 1'b1;
				in0_next = ~{service, 2'b00, btn[mcr3_input_pkg::JOY_FIRE_A],
					btn[mcr3_input_pkg::JOY_FIRE_E], btn[mcr3_input_pkg::JOY_SHIFT], 1'b0,
					btn[mcr3_input_pkg::JOY_COIN]};
				// Spinner angle goes out as is
				in1_next = angle;
				in2_next = ~{1'b0, btn[mcr3_input_pkg::JOY_FIRE_B], 1'b0,
					btn[mcr3_input_pkg::JOY_FIRE_C], btn[mcr3_input_pkg::JOY_DOWN],
					btn[mcr3_input_pkg::JOY_UP], 2'b00};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			input_0   <= mcr3_input_pkg::PORT_IDLE;
			input_1   <= mcr3_input_pkg::PORT_IDLE;
			input_2   <= mcr3_input_pkg::PORT_IDLE;
			landscape <= 1'b0;
		end else begin
			input_0   <= in0_next;
			input_1   <= in1_next;
			input_2   <= in2_next;
			landscape <= landscape_next;
		end
	end

	// DIP byte 0 and the unused port need no formatting
	assign input_3 = dip0;
	assign input_4 = mcr3_input_pkg::PORT_IDLE;

endmodule

`default_nettype wire

// ==== rtl/mcr3_input_pkg.sv ====
//======================================================================
// MCR3 scrolling input package
// Game and steering types, joystick bit map and emulation constants
//======================================================================
`default_nettype none

package mcr3_input_pkg;

	// Game selection as decoded from the game byte
	typedef enum logic [1:0] {
		game_spy_hunter = 2'd0,
		game_turbo      = 2'd1,
		game_crater     = 2'd2,
		game_none       = 2'd3
	} game_e;

	// Source of the steering value on the driving games
	typedef enum logic [1:0] {
		steer_digital  = 2'd0,
		steer_analog_x = 2'd1,
		steer_paddle   = 2'd2
	} steer_mode_e;

	//==================================================================
	// Joystick word bit positions
	//==================================================================
	localparam int JOY_RIGHT  = 0;
	localparam int JOY_LEFT   = 1;
	localparam int JOY_DOWN   = 2;
	localparam int JOY_UP     = 3;
	localparam int JOY_FIRE_A = 4;
	localparam int JOY_FIRE_B = 5;
	localparam int JOY_FIRE_C = 6;
	localparam int JOY_FIRE_D = 7;
	localparam int JOY_FIRE_E = 8;
	localparam int JOY_SHIFT  = 9;
	localparam int JOY_COIN   = 10;
	localparam int JOY_SPCCW  = 30;
	localparam int JOY_SPCW   = 31;

	//==================================================================
	// Download port
	//==================================================================
	localparam logic [7:0] DL_INDEX_GAME = 8'd1;
	localparam logic [7:0] DL_INDEX_DIP  = 8'd254;
	localparam int         DIP_COUNT     = 8;

	// Value of an input port with nothing pressed
	localparam logic [7:0] PORT_IDLE = 8'hFF;

	//==================================================================
	// Emulation constants
	//==================================================================
	// Center is also the base for analog and paddle steering
	localparam logic [7:0] STEER_CENTER = 8'h70;
	localparam logic [7:0] STEER_STEP   = 8'd4;
	localparam logic [7:0] STEER_MAX    = 8'hE0;
	localparam logic [7:0] GAS_STEP     = 8'd8;
	localparam logic [7:0] SPIN_STEP    = 8'd5;

endpackage

`default_nettype wire

// ==== rtl/mcr3_input_top.sv ====
//======================================================================
// MCR3 scrolling input top level
// Download decode, player selection, emulation and port formatting
//======================================================================
`default_nettype none
`timescale 1ns/1ps

module mcr3_input_top (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  wire         dl_wr,
	input  wire  [7:0]  dl_index,
	input  wire  [24:0] dl_addr,
	input  wire  [7:0]  dl_data,
	input  wire  [31:0] joy1,
	input  wire  [31:0] joy2,
	input  wire  [15:0] joy1_a,
	input  wire  [15:0] joy2_a,
	input  wire  [8:0]  sp1,
	input  wire  [8:0]  sp2,
	input  wire  [7:0]  pd1,
	input  wire  [7:0]  pd2,
	input  wire         vsync,
	input  wire         opt_analog_gas,
	input  wire  mcr3_input_pkg::steer_mode_e steer_mode,
	input  wire         port_sel,
	output logic [7:0]  input_0,
	output logic [7:0]  input_1,
	output logic [7:0]  input_2,
	output logic [7:0]  input_3,
	output logic [7:0]  input_4,
	output logic        landscape
);

	mcr3_input_pkg::game_e game;
	logic [7:0]  dip0;
	logic        service;
	logic [31:0] btn;
	logic [15:0] joy_a;
	logic [8:0]  sp;
	logic [7:0]  pd;
	logic        frame_tick;
	logic [7:0]  steering;
	logic [7:0]  gas;
	logic [7:0]  angle;

	//==================================================================
	// Input side
	//==================================================================
	dl_config u_dl_config (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.dl_wr   (dl_wr),
		.dl_index(dl_index),
		.dl_addr (dl_addr),
		.dl_data (dl_data),
		.game    (game),
		.dip0    (dip0),
		.service (service)
	);

	player_select u_player_select (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.joy1      (joy1),
		.joy2      (joy2),
		.joy1_a    (joy1_a),
		.joy2_a    (joy2_a),
		.sp1       (sp1),
		.sp2       (sp2),
		.pd1       (pd1),
		.pd2       (pd2),
		.vsync     (vsync),
		.btn       (btn),
		.joy_a     (joy_a),
		.sp        (sp),
		.pd        (pd),
		.frame_tick(frame_tick)
	);

	//==================================================================
	// Emulation
	//==================================================================
	// Right/left steer, up/down work the gas pedal
	steering_emu u_steering_emu (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.frame_tick (frame_tick),
		.steer_plus (btn[mcr3_input_pkg::JOY_RIGHT]),
		.steer_minus(btn[mcr3_input_pkg::JOY_LEFT]),
		.gas_plus   (btn[mcr3_input_pkg::JOY_UP]),
		.gas_minus  (btn[mcr3_input_pkg::JOY_DOWN]),
		.steering   (steering),
		.gas        (gas)
	);

	spinner_emu u_spinner_emu (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.frame_tick(frame_tick),
		.spin_plus (btn[mcr3_input_pkg::JOY_RIGHT] | btn[mcr3_input_pkg::JOY_SPCW]),
		.spin_minus(btn[mcr3_input_pkg::JOY_LEFT] | btn[mcr3_input_pkg::JOY_SPCCW]),
		.sp        (sp),
		.angle     (angle)
	);

	//==================================================================
	// Output side
	//==================================================================
	input_port_mux u_input_port_mux (
		.clk_sys       (clk_sys),
		.arst_n        (arst_n),
		.game          (game),
		.dip0          (dip0),
		.service       (service),
		.btn           (btn),
		.joy_a         (joy_a),
		.pd            (pd),
		.steering      (steering),
		.gas           (gas),
		.angle         (angle),
		.opt_analog_gas(opt_analog_gas),
		.steer_mode    (steer_mode),
		.port_sel      (port_sel),
		.input_0       (input_0),
		.input_1       (input_1),
		.input_2       (input_2),
		.input_3       (input_3),
		.input_4       (input_4),
		.landscape     (landscape)
	);

endmodule

`default_nettype wire

// ==== rtl/player_select.sv ====
//======================================================================
// Player input selection
// Merges both joysticks, follows the last active analog source
//======================================================================
`default_nettype none
`timescale 1ns/1ps

module player_select (
	input  wire         clk_sys,
	input  wire         arst_n,
	input  wire  [31:0] joy1,
	input  wire  [31:0] joy2,
	input  wire  [15:0] joy1_a,
	input  wire  [15:0] joy2_a,
	input  wire  [8:0]  sp1,
	input  wire  [8:0]  sp2,
	input  wire  [7:0]  pd1,
	input  wire  [7:0]  pd2,
	input  wire         vsync,
	output logic [31:0] btn,
	output logic [15:0] joy_a,
	output logic [8:0]  sp,
	output logic [7:0]  pd,
	output logic        frame_tick
);

	logic       stick_sel;
	logic       stick_sel_next;
	logic [8:0] sp1_d;
	logic [8:0] sp2_d;
	logic       sp_sel;
	logic       sp_sel_next;
	logic [7:0] pd1_d;
	logic [7:0] pd2_d;
	logic       pd_sel;
	logic       pd_sel_next;
	logic       vsync_d;

	// Player 2 takes over on a change unless player 1 also changed
	function automatic logic next_sel(input logic cur, input logic chg1, input logic chg2);
		logic sel;
		sel = cur;
		if (chg2)
			sel = 1'b1;
		if (chg1)
			sel = 1'b0;
		return sel;
	endfunction

	always_comb begin
		stick_sel_next = stick_sel;
		if (|joy2)
			stick_sel_next = 1'b1;
		// Player 1 wins a tie on the stick
		if (|joy1)
			stick_sel_next = 1'b0;
		sp_sel_next = next_sel(sp_sel, sp1 != sp1_d, sp2 != sp2_d);
		pd_sel_next = next_sel(pd_sel, pd1 != pd1_d, pd2 != pd2_d);
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			btn        <= '0;
			joy_a      <= '0;
			sp         <= '0;
			pd         <= '0;
			frame_tick <= 1'b0;
			stick_sel  <= 1'b0;
			sp_sel     <= 1'b0;
			pd_sel     <= 1'b0;
			sp1_d      <= '0;
			sp2_d      <= '0;
			pd1_d      <= '0;
			pd2_d      <= '0;
			vsync_d    <= 1'b0;
		end else begin
			btn        <= joy1 | joy2;
			stick_sel  <= stick_sel_next;
			sp_sel     <= sp_sel_next;
			pd_sel     <= pd_sel_next;
			joy_a      <= stick_sel_next ? joy2_a : joy1_a;
			sp         <= sp_sel_next ? sp2 : sp1;
			pd         <= pd_sel_next ? pd2 : pd1;
			sp1_d      <= sp1;
			sp2_d      <= sp2;
			pd1_d      <= pd1;
			pd2_d      <= pd2;
			// One cycle pulse after each vsync rising edge
			vsync_d    <= vsync;
			frame_tick <= vsync & ~vsync_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/spinner_emu.sv ====
//======================================================================
// Spinner angle accumulator
// Adds spinner deltas and per-frame rotate steps, wrapping at 256
//======================================================================
`default_nettype none
`timescale 1ns/1ps

module spinner_emu (
	input  wire        clk_sys,
	input  wire        arst_n,
	input  wire        frame_tick,
	input  wire        spin_plus,
	input  wire        spin_minus,
	input  wire  [8:0] sp,
	output logic [7:0] angle
);

	logic [8:0] sp_prev;
	logic [7:0] sp_delta;
	logic [7:0] tick_delta;

	always_comb begin
		// Bit 8 toggles on each update, so only the low byte carries movement
		sp_delta = '0;
		if (sp != sp_prev)
			sp_delta = sp[7:0] - sp_prev[7:0];

		tick_delta = '0;
		if (frame_tick) begin
			if (spin_plus)
				tick_delta = mcr3_input_pkg::SPIN_STEP;
			else if (spin_minus)
				tick_delta = 8'd0 - mcr3_input_pkg::SPIN_STEP;
		end
	end

	// Both contributions apply in the same cycle
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sp_prev <= '0;
			angle   <= '0;
		end else begin
			sp_prev <= sp;
			angle   <= angle + sp_delta + tick_delta;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/steering_emu.sv ====
//======================================================================
// Digital steering and gas emulation
// Steps both values once per frame and saturates at their limits
//======================================================================
`default_nettype none
`timescale 1ns/1ps

module steering_emu (
	input  wire        clk_sys,
	input  wire        arst_n,
	input  wire        frame_tick,
	input  wire        steer_plus,
	input  wire        steer_minus,
	input  wire        gas_plus,
	input  wire        gas_minus,
	output logic [7:0] steering,
	output logic [7:0] gas
);

	logic [7:0] steering_next;
	logic [7:0] gas_next;

	// Plus has priority over minus on both controls
	always_comb begin
		steering_next = steering;
		if (steer_plus) begin
			if (steering >= mcr3_input_pkg::STEER_MAX - mcr3_input_pkg::STEER_STEP)
				steering_next = mcr3_input_pkg::STEER_MAX;
			else
				steering_next = steering + mcr3_input_pkg::STEER_STEP;
		end else if (steer_minus) begin
			if (steering < mcr3_input_pkg::STEER_STEP)
				steering_next = '0;
			else
				steering_next = steering - mcr3_input_pkg::STEER_STEP;
		end

		gas_next = gas;
		if (gas_plus) begin
			if (gas >= 8'hFF - mcr3_input_pkg::GAS_STEP)
				gas_next = 8'hFF;
			else
				gas_next = gas + mcr3_input_pkg::GAS_STEP;
		end else if (gas_minus) begin
			if (gas < mcr3_input_pkg::GAS_STEP)
				gas_next = '0;
			else
				gas_next = gas - mcr3_input_pkg::GAS_STEP;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			steering <= mcr3_input_pkg::STEER_CENTER;
			gas      <= '0;
		end else if (frame_tick) begin
			steering <= steering_next;
			gas      <= gas_next;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the MCR3 input testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_mcr3_input \
	--Mdir obj_dir -o sim_mcr3_input
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out="$(./obj_dir/sim_mcr3_input)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// ==== testbench/tb_model.svh ====
//======================================================================
// Reference model for the MCR3 input testbench
// Emulated controls, player selection state and per-game port layout
//======================================================================
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0] m_steer;
logic [7:0] m_gas;
logic [7:0] m_angle;
logic       m_stick_p2;
logic       m_sp_p2;
logic       m_pd_p2;

// One saturating step, up has priority over down
function automatic logic [7:0] sat_step(input logic [7:0] v, input logic up, input logic dn,
	input logic [7:0] step, input logic [7:0] top);
	int r;
	r = int'(v);
	if (up)
		r = r + int'(step);
	else if (dn)
		r = r - int'(step);
	if (r > int'(top))
		r = int'(top);
	if (r < 0)
		r = 0;
	return r[7:0];
endfunction

// State change of one frame tick with buttons b held
task automatic model_frame(input logic [31:0] b);
	m_steer = sat_step(m_steer, b[mcr3_input_pkg::JOY_RIGHT], b[mcr3_input_pkg::JOY_LEFT],
		mcr3_input_pkg::STEER_STEP, mcr3_input_pkg::STEER_MAX);
	m_gas = sat_step(m_gas, b[mcr3_input_pkg::JOY_UP], b[mcr3_input_pkg::JOY_DOWN],
		mcr3_input_pkg::GAS_STEP, 8'hFF);
	if (b[mcr3_input_pkg::JOY_RIGHT] || b[mcr3_input_pkg::JOY_SPCW])
		m_angle = m_angle + mcr3_input_pkg::SPIN_STEP;
	else if (b[mcr3_input_pkg::JOY_LEFT] || b[mcr3_input_pkg::JOY_SPCCW])
		m_angle = m_angle - mcr3_input_pkg::SPIN_STEP;
endtask

function automatic logic [7:0] exp_in0(input mcr3_input_pkg::game_e g, input logic [31:0] b,
	input logic srv, input logic opt, input logic [7:0] ay);
	logic [7:0] v;
	v = 8'h00;
	v[7] = srv;
	v[0] = b[mcr3_input_pkg::JOY_COIN];
	case (g)
		mcr3_input_pkg::game_spy_hunter: v[4] = b[mcr3_input_pkg::JOY_SHIFT];
		mcr3_input_pkg::game_turbo:      v[4] = opt ? ~ay[7] : b[mcr3_input_pkg::JOY_SHIFT];
		mcr3_input_pkg::game_crater: begin
			v[4] = b[mcr3_input_pkg::JOY_FIRE_A];
			v[3] = b[mcr3_input_pkg::JOY_FIRE_E];
			v[2] = b[mcr3_input_pkg::JOY_SHIFT];
		end
		default: v = 8'h00;
	endcase
	return ~v;
endfunction

function automatic logic [7:0] exp_in1(input mcr3_input_pkg::game_e g, input logic [31:0] b);
	logic [7:0] v;
	v = 8'h00;
	if (g == mcr3_input_pkg::game_crater)
		return m_angle;
	if (g == mcr3_input_pkg::game_spy_hunter)
		v[4:0] = {b[4], b[6], b[8], b[5], b[7]};
	else if (g == mcr3_input_pkg::game_turbo)
		v[4:0] = {b[8], b[7], b[6], b[5], b[4]};
	return ~v;
endfunction

function automatic logic [7:0] exp_in2(input mcr3_input_pkg::game_e g, input logic [31:0] b,
	input logic psel, input logic opt, input mcr3_input_pkg::steer_mode_e mode,
	input logic [7:0] ax, input logic [7:0] ay, input logic [7:0] p);
	logic signed [7:0] half;
	logic [7:0]        gv;
	logic [7:0]        v;
	if (g == mcr3_input_pkg::game_crater) begin
		v = 8'h00;
		v[6] = b[mcr3_input_pkg::JOY_FIRE_B];
		v[4] = b[mcr3_input_pkg::JOY_FIRE_C];
		v[3] = b[mcr3_input_pkg::JOY_DOWN];
		v[2] = b[mcr3_input_pkg::JOY_UP];
		return ~v;
	end
	if (g == mcr3_input_pkg::game_none)
		return 8'hFF;
	if (psel) begin
		if (mode == mcr3_input_pkg::steer_analog_x)
			half = $signed(ax) >>> 1;
		else if (mode == mcr3_input_pkg::steer_paddle)
			half = $signed(p ^ 8'h80) >>> 1;
		else
			return m_steer;
		return mcr3_input_pkg::STEER_CENTER + half;
	end
	if (!opt)
		return m_gas;
	// Pushing up gives a negative vertical axis
	if (ay[7])
		gv = 8'd0 - ay;
	else if (g == mcr3_input_pkg::game_turbo)
		gv = ay;
	else
		gv = 8'h00;
	return {gv[6:0], 1'b1};
endfunction

`endif

// ==== testbench/tb_mcr3_input.sv ====
//======================================================================
// MCR3 scrolling input testbench
// Seeded random stimulus checked against a reference model
//======================================================================
`default_nettype none
`timescale 1ns/1ps

module tb_mcr3_input;

	logic        clk_sys;
	logic        arst_n;
	logic        dl_wr;
	logic [7:0]  dl_index;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic [31:0] joy1;
	logic [31:0] joy2;
	logic [15:0] joy1_a;
	logic [15:0] joy2_a;
	logic [8:0]  sp1;
	logic [8:0]  sp2;
	logic [7:0]  pd1;
	logic [7:0]  pd2;
	logic        vsync;
	logic        opt_analog_gas;
	logic        port_sel;
	logic [7:0]  input_0;
	logic [7:0]  input_1;
	logic [7:0]  input_2;
	logic [7:0]  input_3;
	logic [7:0]  input_4;
	logic        landscape;
	mcr3_input_pkg::steer_mode_e steer_mode;
	mcr3_input_pkg::game_e       cur_game;
	logic [7:0]  dip [8];
	int          checks;
	int          errors;

`include "tb_model.svh"

	mcr3_input_top dut0 (.*);

	initial clk_sys = 1'b0;
	always #10 clk_sys = ~clk_sys;

	// Inputs change 2 ns after the edge, outputs are sampled at the same point
	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
			#2;
		end
	endtask

	task automatic check_port(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_game(input mcr3_input_pkg::game_e got,
		input mcr3_input_pkg::game_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: game got %s expected %s", $time, got.name(), exp.name());
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic report(input string name, input int start);
		$display("test %-9s %s, %0d errors", name, (errors == start) ? "ok" : "FAILED",
			errors - start);
	endtask

	task automatic dl_write(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		dl_wr    = 1'b1;
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		wait_cycles(1);
		dl_wr = 1'b0;
	endtask

	task automatic set_game(input logic [7:0] code);
		dl_write(mcr3_input_pkg::DL_INDEX_GAME, 25'd0, code);
		cur_game = (code < 8'd3) ? mcr3_input_pkg::game_e'(code[1:0]) : mcr3_input_pkg::game_none;
		wait_cycles(3);
	endtask

	// Player 1 wins the stick when both are active
	task automatic set_joy(input logic [31:0] j1, input logic [31:0] j2);
		joy1 = j1;
		joy2 = j2;
		if (|j2)
			m_stick_p2 = 1'b1;
		if (|j1)
			m_stick_p2 = 1'b0;
	endtask

	task automatic set_sp(input logic p2, input logic [8:0] val);
		logic [8:0] old_out;
		logic [8:0] new_out;
		old_out = m_sp_p2 ? sp2 : sp1;
		if (p2) begin
			if (val != sp2)
				m_sp_p2 = 1'b1;
			sp2 = val;
		end else begin
			if (val != sp1)
				m_sp_p2 = 1'b0;
			sp1 = val;
		end
		new_out = m_sp_p2 ? sp2 : sp1;
		m_angle = m_angle + (new_out[7:0] - old_out[7:0]);
	endtask

	task automatic set_pd(input logic p2, input logic [7:0] val);
		if (p2) begin
			if (val != pd2)
				m_pd_p2 = 1'b1;
			pd2 = val;
		end else begin
			if (val != pd1)
				m_pd_p2 = 1'b0;
			pd1 = val;
		end
	endtask

	task automatic pulse_frame();
		int n;
		n = 0;
		vsync = 1'b1;
		wait_cycles(1);
		vsync = 1'b0;
		while (dut0.frame_tick !== 1'b1 && n < 8) begin
			wait_cycles(1);
			n++;
		end
		if (dut0.frame_tick !== 1'b1) begin
			errors++;
			$display("No frame tick seen within 8 cycles of a vsync pulse at %0t", $time);
		end
		model_frame(joy1 | joy2);
		wait_cycles(2);
	endtask

	task automatic check_ports(input string what);
		logic [31:0] b;
		logic [15:0] a;
		logic [7:0]  p;
		b = joy1 | joy2;
		a = m_stick_p2 ? joy2_a : joy1_a;
		p = m_pd_p2 ? pd2 : pd1;
		check_port(input_0, exp_in0(cur_game, b, dip[1][0], opt_analog_gas, a[15:8]),
			{what, " input_0"});
		check_port(input_1, exp_in1(cur_game, b), {what, " input_1"});
		check_port(input_2, exp_in2(cur_game, b, port_sel, opt_analog_gas, steer_mode,
			a[7:0], a[15:8], p), {what, " input_2"});
		check_port(input_3, dip[0], {what, " input_3"});
		check_port(input_4, 8'hFF, {what, " input_4"});
		check_flag(landscape, cur_game == mcr3_input_pkg::game_crater, {what, " landscape"});
	endtask

	initial begin
		int          start;
		int          frames;
		int unsigned r;
		logic [31:0] dirs;
		r = $urandom(32'h12ec_f7a9);
		checks = 0;
		errors = 0;
		arst_n = 1'b0;
		dl_wr = 1'b0;
		dl_index = 8'd0;
		dl_addr = 25'd0;
		dl_data = 8'd0;
		joy1 = '0;
		joy2 = '0;
		joy1_a = '0;
		joy2_a = '0;
		sp1 = '0;
		sp2 = '0;
		pd1 = '0;
		pd2 = '0;
		vsync = 1'b0;
		opt_analog_gas = 1'b0;
		port_sel = 1'b0;
		steer_mode = mcr3_input_pkg::steer_digital;
		cur_game = mcr3_input_pkg::game_none;
		m_steer = mcr3_input_pkg::STEER_CENTER;
		m_gas = 8'h00;
		m_angle = 8'h00;
		m_stick_p2 = 1'b0;
		m_sp_p2 = 1'b0;
		m_pd_p2 = 1'b0;

		//==============================================================
		// Reset values, DIP bank and game selection
		//==============================================================
		start = errors;
		repeat (2) @(posedge clk_sys);
		#2;
		// Ports still held in reset
		check_port(input_0, 8'hFF, "reset input_0");
		check_port(input_1, 8'hFF, "reset input_1");
		check_port(input_2, 8'hFF, "reset input_2");
		check_port(input_4, 8'hFF, "reset input_4");
		check_flag(landscape, 1'b0, "reset landscape");
		arst_n = 1'b1;
		wait_cycles(1);
		check_game(dut0.game, mcr3_input_pkg::game_none);
		for (int i = 0; i < 8; i++) begin
			dip[i] = 8'($urandom);
			dl_write(mcr3_input_pkg::DL_INDEX_DIP, 25'(i), dip[i]);
		end
		// Beyond the bank, must not land in byte 0
		dl_write(mcr3_input_pkg::DL_INDEX_DIP, 25'd8, ~dip[0]);
		wait_cycles(2);
		check_port(input_3, dip[0], "dip input_3");
		for (int code = 0; code < 4; code++) begin
			set_game(8'(code));
			check_game(dut0.game, cur_game);
			check_flag(landscape, code == 2, "game landscape");
			check_port(input_3, dip[0], "game input_3");
		end
		report("download", start);

		//==============================================================
		// Button layout per game
		//==============================================================
		start = errors;
		for (int code = 0; code < 4; code++) begin
			set_game(8'(code));
			repeat (16) begin
				set_joy($urandom, $urandom);
				opt_analog_gas = 1'($urandom % 2);
				wait_cycles(2);
				check_ports("buttons");
				wait_cycles(1);
			end
		end
		set_joy('0, '0);
		opt_analog_gas = 1'b0;
		report("buttons", start);

		//==============================================================
		// Digital steering and gas, saturating both ways first
		//==============================================================
		start = errors;
		set_game(8'd0);
		for (int i = 0; i < 24; i++) begin
			if (i == 0)
				dirs = 32'h9;
			else if (i == 1)
				dirs = 32'h6;
			else
				dirs = $urandom & 32'hF;
			frames = (i < 2) ? 60 : 1 + int'($urandom % 8);
			if ($urandom % 2)
				set_joy(dirs, '0);
			else
				set_joy('0, dirs);
			repeat (frames) begin
				pulse_frame();
				port_sel = 1'b1;
				wait_cycles(1);
				check_ports("steering");
				port_sel = 1'b0;
				wait_cycles(1);
				check_ports("gas");
			end
		end
		set_joy('0, '0);
		report("digital", start);

		//==============================================================
		// Analog stick, paddle and analog gas with player switching
		//==============================================================
		start = errors;
		for (int code = 0; code < 2; code++) begin
			set_game(8'(code));
			repeat (40) begin
				r = $urandom % 3;
				set_joy((r != 1) ? 32'h10 : '0, (r != 0) ? 32'h10 : '0);
				wait_cycles(1);
				set_joy('0, '0);
				joy1_a = 16'($urandom);
				joy2_a = 16'($urandom);
				set_pd(1'($urandom % 2), 8'($urandom));
				steer_mode = mcr3_input_pkg::steer_mode_e'(2'($urandom % 3));
				opt_analog_gas = 1'($urandom % 2);
				port_sel = 1'($urandom % 2);
				wait_cycles(2);
				check_ports("analog");
			end
		end
		report("analog", start);

		//==============================================================
		// Crater spinner with rotate buttons and frame ticks
		//==============================================================
		start = errors;
		steer_mode = mcr3_input_pkg::steer_digital;
		opt_analog_gas = 1'b0;
		set_game(8'd2);
		repeat (60) begin
			dirs = $urandom & 32'hC000_006F;
			if ($urandom % 2)
				set_joy(dirs, '0);
			else
				set_joy('0, dirs);
			r = $urandom % 3;
			if (r < 2)
				set_sp(r[0], 9'($urandom));
			if ($urandom % 2)
				pulse_frame();
			else
				wait_cycles(3);
			check_ports("spinner");
		end
		report("spinner", start);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
